//--- filelist.f
md_pkg.sv
md_operand_stage.sv
md_mult_fast.sv
md_div_long.sv
md_imd_regs.sv
md_top.sv
tb_md_top.sv

//--- tb_md_top.sv
/*
 * Testbench for the multiply/divide unit
 * Random and corner operands against a reference model under result back-pressure
 */
module tb_md_top;
  import md_pkg::*;

  // Total ops over the mull, mulh, div/rem, zero/overflow and back-pressure tests
  localparam int NUM_OPS   = 274;
  localparam int WD_MARGIN = 4000;

  logic            clk_i;
  logic            rst_ni;
  logic            req_i;
  md_op_e          operator_i;
  logic [1:0]      signed_mode_i;
  logic [XLEN-1:0] op_a_i;
  logic [XLEN-1:0] op_b_i;
  logic            ready_o;
  logic            result_ready_i;
  logic            valid_o;
  logic [XLEN-1:0] result_o;

  logic [31:0]     rng;
  int              err_cnt;
  int              done_cnt;
  // Expected result and stall length per accepted request
  logic [31:0]     exp_q [$];
  int              stall_q [$];

  md_top UUT (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req_i),
    .operator_i     (operator_i),
    .signed_mode_i  (signed_mode_i),
    .op_a_i         (op_a_i),
    .op_b_i         (op_b_i),
    .ready_o        (ready_o),
    .result_ready_i (result_ready_i),
    .valid_o        (valid_o),
    .result_o       (result_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift(rng);
    return rng;
  endfunction

  // Corner operands zero, minus one and most negative
  function automatic logic [31:0] corner(input int idx);
    case (idx)
      0:       return 32'h0000_0000;
      1:       return 32'hffff_ffff;
      default: return 32'h8000_0000;
    endcase
  endfunction

  // RISC-V M results with each operand signed by its own mode bit
  function automatic logic [31:0] md_ref(input md_op_e op, input logic [1:0] mode,
                                         input logic [31:0] a, input logic [31:0] b);
    logic [63:0] ext_a;
    logic [63:0] ext_b;
    logic [63:0] prod;
    logic        neg_a;
    logic        neg_b;
    logic [31:0] mag_a;
    logic [31:0] mag_b;
    logic [31:0] quot;
    logic [31:0] rem;
    ext_a = mode[0] ? {{32{a[31]}}, a} : {32'd0, a};
    ext_b = mode[1] ? {{32{b[31]}}, b} : {32'd0, b};
    prod  = ext_a * ext_b;
    neg_a = mode[0] & a[31];
    neg_b = mode[1] & b[31];
    mag_a = neg_a ? 32'd0 - a : a;
    mag_b = neg_b ? 32'd0 - b : b;
    if (b == 32'd0) begin
      quot = 32'hffff_ffff;
      rem  = a;
    end else begin
      // Truncating division with the remainder taking the dividend sign
      quot = mag_a / mag_b;
      rem  = mag_a % mag_b;
      if (neg_a ^ neg_b) quot = 32'd0 - quot;
      if (neg_a) rem = 32'd0 - rem;
    end
    case (op)
      MD_OP_MULL: return prod[31:0];
      MD_OP_MULH: return prod[63:32];
      MD_OP_DIV:  return quot;
      default:    return rem;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      err_cnt++;
      $display("ERR t=%0t %s exp=%h act=%h", $time, name, exp, act);
    end
  endtask

  // Raise a request and hold it until the DUT takes it
  task automatic issue_op(input md_op_e op, input logic [1:0] mode,
                          input logic [31:0] a, input logic [31:0] b, input int stall);
    logic accepted;
    accepted = 1'b0;
    @(posedge clk_i);
    req_i         <= 1'b1;
    operator_i    <= op;
    signed_mode_i <= mode;
    op_a_i        <= a;
    op_b_i        <= b;
    while (!accepted) begin
      @(negedge clk_i);
      if (ready_o) begin
        accepted = 1'b1;
        if (exp_q.size() != 0) begin
          err_cnt++;
          $display("Request accepted at %0t while a result was still pending", $time);
        end
        exp_q.push_back(md_ref(op, mode, a, b));
        stall_q.push_back(stall);
      end
      @(posedge clk_i);
    end
    req_i <= 1'b0;
  endtask

  task automatic report_test(input string name, input int ops, input int errs_before);
    while (exp_q.size() != 0) @(negedge clk_i);
    @(posedge clk_i);
    $display("Test %s: %0d ops, %0d errors", name, ops, err_cnt - errs_before);
  endtask

  // Result side with back-pressure, hold checks and comparison against the model
  initial begin : compare_results
    logic [31:0] held;
    logic [31:0] exp_val;
    logic        holding;
    logic        next_ready;
    int          stalled;
    result_ready_i = 1'b0;
    holding        = 1'b0;
    stalled        = 0;
    @(posedge rst_ni);
    forever begin
      @(negedge clk_i);
      next_ready = result_ready_i;
      if (valid_o && exp_q.size() == 0) begin
        err_cnt++;
        $display("Result valid at %0t with no request outstanding", $time);
        next_ready = 1'b1;
      end else if (valid_o) begin
        // Result and ready_o frozen until the transfer
        if (!holding) begin
          held    = result_o;
          holding = 1'b1;
        end else begin
          check_value("result_o", held, result_o);
        end
        check_value("ready_o", 32'd0, {31'd0, ready_o});
        if (result_ready_i) begin
          exp_val = exp_q.pop_front();
          stall_q.delete(0);
          check_value("result_o", exp_val, result_o);
          done_cnt++;
          holding    = 1'b0;
          stalled    = 0;
          next_ready = 1'b0;
        end else if (stalled >= stall_q[0]) begin
          next_ready = 1'b1;
        end else begin
          stalled++;
        end
      end else begin
        // A shown result must stay valid until it is taken
        if (holding) begin
          err_cnt++;
          $display("valid_o dropped at %0t before the result was taken", $time);
          holding = 1'b0;
        end
        // Ready goes up before valid when no stall is wanted
        next_ready = (stall_q.size() != 0) && (stall_q[0] == 0);
      end
      @(posedge clk_i);
      result_ready_i <= next_ready;
    end
  end

  initial begin : watchdog
    #(NUM_OPS * 40 * 4 + WD_MARGIN);
    $display("Timeout: the operations did not all complete in time");
    $display("Simulation FAILED");
    $finish;
  end

  initial begin : stimulus
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    logic [1:0]  mode;
    md_op_e      op;
    int          errs;
    rng           = 32'he1be_1bd5;
    err_cnt       = 0;
    done_cnt      = 0;
    rst_ni        = 1'b0;
    req_i         = 1'b0;
    operator_i    = MD_OP_MULL;
    signed_mode_i = 2'b00;
    op_a_i        = '0;
    op_b_i        = '0;
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;

    errs = err_cnt;
    @(negedge clk_i);
    check_value("valid_o", 32'd0, {31'd0, valid_o});
    check_value("ready_o", 32'd1, {31'd0, ready_o});
    report_test("reset", 0, errs);

    errs = err_cnt;
    for (int m = 0; m < 4; m++) begin
      for (int i = 0; i < 16; i++) begin
        issue_op(MD_OP_MULL, m[1:0], next_rand(), next_rand(), 0);
      end
    end
    report_test("mull", 64, errs);

    errs = err_cnt;
    for (int m = 0; m < 4; m++) begin
      for (int i = 0; i < 16; i++) begin
        issue_op(MD_OP_MULH, m[1:0], next_rand(), next_rand(), 0);
      end
      for (int i = 0; i < 3; i++) begin
        for (int j = 0; j < 3; j++) begin
          issue_op(MD_OP_MULH, m[1:0], corner(i), corner(j), 0);
        end
      end
    end
    report_test("mulh", 100, errs);

    // Divisor shifted down by a random amount to spread its magnitude
    errs = err_cnt;
    for (int k = 0; k < 4; k++) begin
      op   = k[0] ? MD_OP_REM : MD_OP_DIV;
      mode = k[1] ? 2'b11 : 2'b00;
      for (int i = 0; i < 20; i++) begin
        r = next_rand();
        a = next_rand();
        b = next_rand() >> r[4:0];
        issue_op(op, mode, a, b, 0);
      end
    end
    report_test("div_rem", 80, errs);

    errs = err_cnt;
    for (int k = 0; k < 4; k++) begin
      op   = k[0] ? MD_OP_REM : MD_OP_DIV;
      mode = k[1] ? 2'b11 : 2'b00;
      issue_op(op, mode, next_rand(), 32'd0, 0);
      issue_op(op, mode, 32'h8000_0000, 32'd0, 0);
    end
    issue_op(MD_OP_DIV, 2'b11, 32'h8000_0000, 32'hffff_ffff, 0);
    issue_op(MD_OP_REM, 2'b11, 32'h8000_0000, 32'hffff_ffff, 0);
    report_test("zero_overflow", 10, errs);

    errs = err_cnt;
    for (int i = 0; i < 20; i++) begin
      r  = next_rand();
      op = md_op_e'(r[1:0]);
      issue_op(op, r[3:2], next_rand(), next_rand() >> r[8:4], 1 + int'(r[11:9]));
    end
    report_test("back_pressure", 20, errs);

    if (done_cnt != NUM_OPS) begin
      err_cnt++;
      $display("Only %0d of %0d operations completed", done_cnt, NUM_OPS);
    end
    $display("Done: %0d operations, %0d errors", done_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- md_top.sv
/*
 * Multiply/divide unit top level
 * Operand stage feeding the multiplier and divider over shared registers
 */
module md_top (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    req_i,
  input  md_pkg::md_op_e          operator_i,
  input  logic [1:0]              signed_mode_i,
  input  logic [md_pkg::XLEN-1:0] op_a_i,
  input  logic [md_pkg::XLEN-1:0] op_b_i,
  output logic                    ready_o,
  input  logic                    result_ready_i,
  output logic                    valid_o,
  output logic [md_pkg::XLEN-1:0] result_o
);
  import md_pkg::*;

  // Held request
  md_op_e          op;
  logic [1:0]      signed_mode;
  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;

  // Engine handshakes
  logic            mult_start;
  logic            div_start;
  logic            mult_done;
  logic            div_done;
  logic            mult_valid;
  logic            div_valid;
  logic [XLEN-1:0] mult_result;

  // Intermediate register traffic
  md_imd_u         imd_q;
  md_imd_u         mult_imd_d;
  logic            mult_imd_we;
  md_imd_u         div_imd_d;
  logic            div_imd_we;
  logic [XLEN-1:0] den_d;
  logic            den_we;
  logic [XLEN-1:0] den_q;

  md_operand_stage u_operand_stage (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .operator_i    (operator_i),
    .signed_mode_i (signed_mode_i),
    .op_a_i        (op_a_i),
    .op_b_i        (op_b_i),
    .mult_done_i   (mult_done),
    .div_done_i    (div_done),
    .ready_o       (ready_o),
    .mult_start_o  (mult_start),
    .div_start_o   (div_start),
    .op_o          (op),
    .signed_mode_o (signed_mode),
    .op_a_o        (op_a),
    .op_b_o        (op_b)
  );

  md_mult_fast u_mult_fast (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .start_i        (mult_start),
    .op_i           (op),
    .signed_mode_i  (signed_mode),
    .op_a_i         (op_a),
    .op_b_i         (op_b),
    .imd_q_i        (imd_q),
    .result_ready_i (result_ready_i),
    .imd_d_o        (mult_imd_d),
    .imd_we_o       (mult_imd_we),
    .result_o       (mult_result),
    .valid_o        (mult_valid),
    .done_o         (mult_done)
  );

  md_div_long u_div_long (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .start_i        (div_start),
    .op_i           (op),
    .signed_mode_i  (signed_mode),
    .op_a_i         (op_a),
    .op_b_i         (op_b),
    .imd_q_i        (imd_q),
    .den_q_i        (den_q),
    .result_ready_i (result_ready_i),
    .imd_d_o        (div_imd_d),
    .imd_we_o       (div_imd_we),
    .den_d_o        (den_d),
    .den_we_o       (den_we),
    .valid_o        (div_valid),
    .done_o         (div_done)
  );

  md_imd_regs u_imd_regs (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .mult_imd_d_i  (mult_imd_d),
    .mult_imd_we_i (mult_imd_we),
    .div_imd_d_i   (div_imd_d),
    .div_imd_we_i  (div_imd_we),
    .den_d_i       (den_d),
    .den_we_i      (den_we),
    .mult_result_i (mult_result),
    .mult_valid_i  (mult_valid),
    .div_valid_i   (div_valid),
    .imd_q_o       (imd_q),
    .den_q_o       (den_q),
    .result_o      (result_o),
    .valid_o       (valid_o)
  );

endmodule

//--- md_imd_regs.sv
/*
 * Intermediate registers
 * Accumulator/remainder word, denominator, and the result mux
 */
module md_imd_regs (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  md_pkg::md_imd_u         mult_imd_d_i,
  input  logic                    mult_imd_we_i,
  input  md_pkg::md_imd_u         div_imd_d_i,
  input  logic                    div_imd_we_i,
  input  logic [md_pkg::XLEN-1:0] den_d_i,
  input  logic                    den_we_i,
  input  logic [md_pkg::XLEN-1:0] mult_result_i,
  input  logic                    mult_valid_i,
  input  logic                    div_valid_i,
  output md_pkg::md_imd_u         imd_q_o,
  output logic [md_pkg::XLEN-1:0] den_q_o,
  output logic [md_pkg::XLEN-1:0] result_o,
  output logic                    valid_o
);

  // Word 0, only one engine is active at a time
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      imd_q_o <= '0;
    end else if (mult_imd_we_i) begin
      imd_q_o <= mult_imd_d_i;
    end else if (div_imd_we_i) begin
      imd_q_o <= div_imd_d_i;
    end
  end

  // Word 1, divider denominator
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      den_q_o <= '0;
    end else if (den_we_i) begin
      den_q_o <= den_d_i;
    end
  end

  // Multiplier result is combinational, divider result sits in word 0
  assign result_o = mult_valid_i ? mult_result_i : imd_q_o.fields.data;
  assign valid_o  = mult_valid_i | div_valid_i;

endmodule

//--- md_div_long.sv
/*
 * Long divider
 * Restoring division, one quotient bit per cycle, with its own adder
 * for absolute values, the compare steps and the final sign fix
 */
module md_div_long (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    start_i,
  input  md_pkg::md_op_e          op_i,
  input  logic [1:0]              signed_mode_i,
  input  logic [md_pkg::XLEN-1:0] op_a_i,
  input  logic [md_pkg::XLEN-1:0] op_b_i,
  input  md_pkg::md_imd_u         imd_q_i,
  input  logic [md_pkg::XLEN-1:0] den_q_i,
  input  logic                    result_ready_i,
  output md_pkg::md_imd_u         imd_d_o,
  output logic                    imd_we_o,
  output logic [md_pkg::XLEN-1:0] den_d_o,
  output logic                    den_we_o,
  output logic                    valid_o,
  output logic                    done_o
);
  import md_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    ABS_A,
    ABS_B,
    COMP,
    LAST,
    CHANGE_SIGN,
    FINISH
  } div_state_e;

  div_state_e       state_q;
  div_state_e       state_d;
  logic [CNT_W-1:0] cnt_q;
  logic [CNT_W-1:0] cnt_d;
  logic [XLEN-1:0]  numer_q;
  logic [XLEN-1:0]  numer_d;
  logic [XLEN-1:0]  quot_q;
  logic [XLEN-1:0]  quot_d;
  logic [XLEN:0]    adder_op_a;
  logic [XLEN:0]    adder_op_b;
  logic [XLEN:0]    adder_sum;
  logic [XLEN-1:0]  adder_res;
  logic [XLEN-1:0]  rem_q;
  logic [XLEN-1:0]  one_shift;
  logic [XLEN-1:0]  next_remainder;
  logic [XLEN-1:0]  next_quotient;
  logic             div_sign_a;
  logic             div_sign_b;
  logic             div_change_sign;
  logic             b_is_zero;
  logic             is_greater_equal;
  logic             div_en;
  md_imd_u          rem_d;

  // Operand b carries ~x with a forced carry-in in bit 0, so the sum is a - x
  assign adder_sum = adder_op_a + adder_op_b;
  assign adder_res = adder_sum[XLEN:1];

  assign rem_q     = imd_q_i.fields.data;
  assign b_is_zero = (op_b_i == '0);

  assign div_sign_a      = signed_mode_i[0] & op_a_i[XLEN-1];
  assign div_sign_b      = signed_mode_i[1] & op_b_i[XLEN-1];
  assign div_change_sign = div_sign_a ^ div_sign_b;

  // Quotient bit for the current step
  assign one_shift = {{(XLEN-1){1'b0}}, 1'b1} << cnt_q;

  // Remainder >= denominator, both magnitudes
  always_comb begin
    if (rem_q[XLEN-1] == den_q_i[XLEN-1]) begin
      is_greater_equal = ~adder_res[XLEN-1];
    end else begin
      is_greater_equal = rem_q[XLEN-1];
    end
  end

  assign next_remainder = is_greater_equal ? adder_res : rem_q;
  assign next_quotient  = is_greater_equal ? (quot_q | one_shift) : quot_q;

  always_comb begin
    state_d    = state_q;
    cnt_d      = cnt_q - 1'b1;
    numer_d    = numer_q;
    quot_d     = quot_q;
    rem_d      = imd_q_i;
    den_d_o    = den_q_i;
    adder_op_a = {{XLEN{1'b0}}, 1'b1};
    adder_op_b = {~op_b_i, 1'b1};

    unique case (state_q)
      IDLE: begin
        // Preload the divide-by-zero answer
        if (op_i == MD_OP_DIV) begin
          rem_d = '1;
        end else begin
          rem_d.fields.guard = 2'b00;
          rem_d.fields.data  = op_a_i;
        end
        state_d = b_is_zero ? FINISH : ABS_A;
        cnt_d   = DIV_LAST_CNT;
      end

      ABS_A: begin
        // |a| = 0 - a when negative
        adder_op_b = {~op_a_i, 1'b1};
        numer_d    = div_sign_a ? adder_res : op_a_i;
        quot_d     = '0;
        state_d    = ABS_B;
        cnt_d      = DIV_LAST_CNT;
      end

      ABS_B: begin
        // |b|, and first numerator bit into the remainder
        den_d_o            = div_sign_b ? adder_res : op_b_i;
        rem_d.fields.guard = 2'b00;
        rem_d.fields.data  = {{(XLEN-1){1'b0}}, numer_q[XLEN-1]};
        state_d            = COMP;
        cnt_d              = DIV_LAST_CNT;
      end

      COMP: begin
        // Remainder minus denominator
        adder_op_a = {rem_q, 1'b1};
        adder_op_b = {~den_q_i, 1'b1};
        // Shift in the next numerator bit
        rem_d.fields.guard = {1'b0, next_remainder[XLEN-1]};
        rem_d.fields.data  = {next_remainder[XLEN-2:0], numer_q[cnt_d]};
        quot_d             = next_quotient;
        state_d            = (cnt_q == 1) ? LAST : COMP;
      end

      LAST: begin
        adder_op_a         = {rem_q, 1'b1};
        adder_op_b         = {~den_q_i, 1'b1};
        // Word 0 keeps only what the operator returns
        rem_d.fields.guard = 2'b00;
        if (op_i == MD_OP_DIV) begin
          rem_d.fields.data = next_quotient;
        end else begin
          rem_d.fields.data = next_remainder;
        end
        state_d = CHANGE_SIGN;
      end

      CHANGE_SIGN: begin
        // 0 - result
        adder_op_b = {~rem_q, 1'b1};
        if (op_i == MD_OP_DIV) begin
          if (div_change_sign) begin
            rem_d.fields.data = adder_res;
          end
        end else if (div_sign_a) begin
          // Remainder follows the dividend sign
          rem_d.fields.data = adder_res;
        end
        state_d = FINISH;
      end

      FINISH: begin
        state_d = IDLE;
      end

      default: begin
        state_d = IDLE;
      end
    endcase
  end

  assign valid_o = (state_q == FINISH);
  assign done_o  = valid_o & result_ready_i;

  // Idle waits for start, FINISH holds under back-pressure
  assign div_en = (state_q == IDLE) ? start_i : ~(valid_o & ~result_ready_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else if (div_en) begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (div_en) begin
      numer_q <= numer_d;
      quot_q  <= quot_d;
    end
  end

  assign imd_d_o  = rem_d;
  assign imd_we_o = div_en;
  assign den_we_o = div_en;

endmodule

//--- md_mult_fast.sv
/*
 * Fast multiplier
 * One 17x17 signed MAC, walked over the four 16-bit partial products
 * MULL done after three steps, MULH after four
 */
module md_mult_fast (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    start_i,
  input  md_pkg::md_op_e          op_i,
  input  logic [1:0]              signed_mode_i,
  input  logic [md_pkg::XLEN-1:0] op_a_i,
  input  logic [md_pkg::XLEN-1:0] op_b_i,
  input  md_pkg::md_imd_u         imd_q_i,
  input  logic                    result_ready_i,
  output md_pkg::md_imd_u         imd_d_o,
  output logic                    imd_we_o,
  output logic [md_pkg::XLEN-1:0] result_o,
  output logic                    valid_o,
  output logic                    done_o
);
  import md_pkg::*;

  typedef enum logic [1:0] {
    ALBL,
    ALBH,
    AHBL,
    AHBH
  } mult_state_e;

  mult_state_e             state_q;
  mult_state_e             state_d;
  logic [HALF_W-1:0]       mult_op_a;
  logic [HALF_W-1:0]       mult_op_b;
  logic                    sign_a;
  logic                    sign_b;
  logic                    signed_mult;
  logic signed [IMD_W-1:0] accum;
  logic signed [IMD_W-1:0] mac_res;
  logic [IMD_W-1:0]        mac_res_d;
  logic                    advance;

  assign signed_mult = |signed_mode_i;

  // The MAC kernel
  // Top result bit would only repeat bit 33, so 34 bits suffice
  assign mac_res = $signed({sign_a, mult_op_a}) * $signed({sign_b, mult_op_b}) + accum;

  always_comb begin
    mult_op_a = op_a_i[HALF_W-1:0];
    mult_op_b = op_b_i[HALF_W-1:0];
    sign_a    = 1'b0;
    sign_b    = 1'b0;
    accum     = imd_q_i.acc;
    mac_res_d = mac_res;
    state_d   = state_q;
    valid_o   = 1'b0;

    unique case (state_q)
      ALBL: begin
        // al*bl, nothing to add yet
        accum   = '0;
        state_d = ALBH;
      end

      ALBH: begin
        // al*bh, plus upper half of al*bl
        mult_op_b = op_b_i[XLEN-1:HALF_W];
        sign_b    = signed_mode_i[1] & op_b_i[XLEN-1];
        accum     = {{(IMD_W-HALF_W){1'b0}}, imd_q_i.acc[XLEN-1:HALF_W]};
        if (op_i == MD_OP_MULL) begin
          // Only the low 16 bits matter for the low word
          mac_res_d = {2'b00, mac_res[HALF_W-1:0], imd_q_i.acc[HALF_W-1:0]};
        end
        state_d = AHBL;
      end

      AHBL: begin
        // ah*bl
        mult_op_a = op_a_i[XLEN-1:HALF_W];
        sign_a    = signed_mode_i[0] & op_a_i[XLEN-1];
        if (op_i == MD_OP_MULL) begin
          accum     = {{(IMD_W-HALF_W){1'b0}}, imd_q_i.acc[XLEN-1:HALF_W]};
          mac_res_d = {2'b00, mac_res[HALF_W-1:0], imd_q_i.acc[HALF_W-1:0]};
          valid_o   = 1'b1;
          state_d   = ALBL;
        end else begin
          state_d = AHBH;
        end
      end

      AHBH: begin
        // ah*bh, plus accumulator shifted down by 16
        mult_op_a = op_a_i[XLEN-1:HALF_W];
        mult_op_b = op_b_i[XLEN-1:HALF_W];
        sign_a    = signed_mode_i[0] & op_a_i[XLEN-1];
        sign_b    = signed_mode_i[1] & op_b_i[XLEN-1];
        // Accumulator is signed unless both operands are unsigned
        accum     = {{HALF_W{signed_mult & imd_q_i.acc[IMD_W-1]}},
                     imd_q_i.acc[IMD_W-1:HALF_W]};
        valid_o   = 1'b1;
        state_d   = ALBL;
      end

      default: begin
        state_d = ALBL;
      end
    endcase
  end

  // Idle waits for start, final state waits for the consumer
  assign advance = (state_q == ALBL) ? start_i : (~valid_o | result_ready_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ALBL;
    end else if (advance) begin
      state_q <= state_d;
    end
  end

  // Partial sums only, word 0 frozen while the result is shown
  assign imd_d_o.acc = mac_res_d;
  assign imd_we_o    = advance & ~valid_o;

  assign result_o = mac_res_d[XLEN-1:0];
  assign done_o   = valid_o & result_ready_i;

endmodule

//--- md_operand_stage.sv
/*
 * Operand stage
 * Accepts one request, holds operator and operands for the engines
 * and issues a start pulse to the engine that serves the operator
 */
module md_operand_stage (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    req_i,
  input  md_pkg::md_op_e          operator_i,
  input  logic [1:0]              signed_mode_i,
  input  logic [md_pkg::XLEN-1:0] op_a_i,
  input  logic [md_pkg::XLEN-1:0] op_b_i,
  input  logic                    mult_done_i,
  input  logic                    div_done_i,
  output logic                    ready_o,
  output logic                    mult_start_o,
  output logic                    div_start_o,
  output md_pkg::md_op_e          op_o,
  output logic [1:0]              signed_mode_o,
  output logic [md_pkg::XLEN-1:0] op_a_o,
  output logic [md_pkg::XLEN-1:0] op_b_o
);
  import md_pkg::*;

  logic            busy_q;
  logic            start_q;
  logic            accept;
  logic            is_mult;
  md_op_e          op_q;
  logic [1:0]      mode_q;
  logic [XLEN-1:0] a_q;
  logic [XLEN-1:0] b_q;

  // One operation in flight at a time
  assign ready_o = ~busy_q;
  assign accept  = req_i & ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q  <= 1'b0;
      start_q <= 1'b0;
    end else begin
      // Start fires in the cycle after acceptance
      start_q <= accept;
      if (accept) begin
        busy_q <= 1'b1;
      end else if (mult_done_i || div_done_i) begin
        busy_q <= 1'b0;
      end
    end
  end

  // Operands stay put until the next acceptance
  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q   <= operator_i;
      mode_q <= signed_mode_i;
      a_q    <= op_a_i;
      b_q    <= op_b_i;
    end
  end

  // Route start by operator class
  assign is_mult      = (op_q == MD_OP_MULL) || (op_q == MD_OP_MULH);
  assign mult_start_o = start_q & is_mult;
  assign div_start_o  = start_q & ~is_mult;

  assign op_o          = op_q;
  assign signed_mode_o = mode_q;
  assign op_a_o        = a_q;
  assign op_b_o        = b_q;

endmodule

//--- md_pkg.sv
/*
 * Multiply/divide unit package
 * Widths, divider counter constants, operator encoding and the
 * intermediate word shared by the multiplier and the divider
 */
package md_pkg;

  // Operand and result width
  localparam int unsigned XLEN = 32;

  // One multiplier half-operand
  localparam int unsigned HALF_W = 16;

  // Intermediate word, data plus two guard bits
  localparam int unsigned IMD_W = 34;

  // Divider iteration counter
  localparam int unsigned CNT_W = 5;

  // Counter start value, one step per quotient bit
  localparam logic [CNT_W-1:0] DIV_LAST_CNT = 5'd31;

  // Operator encoding
  typedef enum logic [1:0] {
    MD_OP_MULL,
    MD_OP_MULH,
    MD_OP_DIV,
    MD_OP_REM
  } md_op_e;

  // Divider view of the intermediate word
  typedef struct packed {
    // Carry and sign guard
    logic [1:0]      guard;
    // Remainder or quotient
    logic [XLEN-1:0] data;
  } md_imd_s;

  // Same word, read as MAC accumulator or as divider fields
  typedef union packed {
    logic signed [IMD_W-1:0] acc;
    md_imd_s                 fields;
  } md_imd_u;

endpackage
